//--- dv/int_issue_asserts.sv
module int_issue_asserts #(
    parameter int RS_DEPTH = 8
) (
    input logic                clk,
    input logic                rst,
    input logic                disp_valid,
    input logic                disp_ready,
    input logic                issue_valid,
    input logic                alu_ready,
    input logic [RS_DEPTH-1:0] busy
);

    // occupancy from the dispatch and issue handshakes
    int occ;

    always_ff @(posedge clk) begin
        if (rst) begin
            occ <= 0;
        end else begin
            occ <= occ + int'(disp_valid && disp_ready) - int'(issue_valid && alu_ready);
        end
    end

    // entries leave only through an issue that needs the unit
    a_no_issue_when_busy: assert property (@(posedge clk) disable iff (rst)
        !alu_ready |=> (($past(busy) & ~busy) == '0))
        else $error("entry left the station while the functional unit was busy");

    // stall only once every entry holds a micro-op
    a_full_when_not_ready: assert property (@(posedge clk) disable iff (rst)
        !disp_ready |-> (occ == RS_DEPTH))
        else $error("dispatch stalled with a free entry");

    // station comes out of reset empty
    a_idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !issue_valid)
        else $error("issue_valid high right after reset");

endmodule

bind int_rs int_issue_asserts #(.RS_DEPTH(RS_DEPTH)) asserts_i (
    .clk         (clk),
    .rst         (rst),
    .disp_valid  (disp_valid),
    .disp_ready  (disp_ready),
    .issue_valid (issue_valid),
    .alu_ready   (alu_ready),
    .busy        (busy)
);

//--- dv/int_issue_tb.sv
module int_issue_tb
    import int_issue_pkg::*;
();
    localparam int TIMEOUT = 500;
    localparam int ROBS    = 2 ** ROB_IDX;

    logic clk = 1'b0;
    logic rst;
    logic disp_valid;
    logic disp_ready;
    uop_t disp_uop;
    cdb_t cdb;

    int errors;
    int timeouts;
    int last_stall;

    // register values in program order
    logic [XLEN-1:0]    ref_regs [PHY_REGS];

    // expected results by rob_id
    logic               pending [ROBS];
    logic [XLEN-1:0]    exp_val [ROBS];
    logic [PHY_IDX-1:0] exp_rd [ROBS];
    logic               use1 [ROBS];
    logic               use2 [ROBS];
    logic [PHY_IDX-1:0] src1 [ROBS];
    logic [PHY_IDX-1:0] src2 [ROBS];
    longint             acc_t [ROBS];
    longint             got_t [ROBS];

    int_issue_top #(.RS_DEPTH(8)) int_issue_top_i (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .disp_uop   (disp_uop),
        .cdb        (cdb)
    );

    always #4 clk = ~clk;

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic logic [XLEN-1:0] alu_model(input fu_op_t op, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (op)
            FU_ADD:  return a + b;
            FU_SUB:  return a - b;
            FU_AND:  return a & b;
            FU_OR:   return a | b;
            FU_XOR:  return a ^ b;
            FU_SLL:  return a << b[4:0];
            FU_SRL:  return a >> b[4:0];
            FU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FU_MUL:  return a * b;
            default: return '0;
        endcase
    endfunction

    function automatic logic writer_pending(input logic [PHY_IDX-1:0] x);
        for (int r = 0; r < ROBS; r++) begin
            if (pending[r] && exp_rd[r] == x) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // written or still to be read by something in flight
    function automatic logic reg_busy(input logic [PHY_IDX-1:0] x);
        for (int r = 0; r < ROBS; r++) begin
            if (pending[r] && ((use1[r] && src1[r] == x) || (use2[r] && src2[r] == x))) begin
                return 1'b1;
            end
        end
        return writer_pending(x);
    endfunction

    function automatic logic any_pending();
        for (int r = 0; r < ROBS; r++) begin
            if (pending[r]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    //////////////////////////////
    // driver and monitor
    //////////////////////////////

    task automatic monitor_cdb();
        forever begin
            @(posedge clk);
            if (cdb.valid) begin
                if (!pending[cdb.rob_id]) begin
                    errors++;
                    $display("[FAIL] %0t: unexpected result for rob %0d", $time, cdb.rob_id);
                end else if (cdb.value !== exp_val[cdb.rob_id]
                             || cdb.rd_phy !== exp_rd[cdb.rob_id]) begin
                    errors++;
                    $display("[FAIL] %0t: rob %0d gave p%0d=%h, expected p%0d=%h", $time,
                             cdb.rob_id, cdb.rd_phy, cdb.value, exp_rd[cdb.rob_id],
                             exp_val[cdb.rob_id]);
                end
                pending[cdb.rob_id] = 1'b0;
                got_t[cdb.rob_id] = $time;
            end
        end
    endtask

    // called and returns at a falling edge
    task automatic dispatch(input logic [ROB_IDX-1:0] rob, input fu_op_t op,
                            input op1_sel_t s1, input op2_sel_t s2,
                            input logic [PHY_IDX-1:0] rs1, input logic [PHY_IDX-1:0] rs2,
                            input logic [PHY_IDX-1:0] rd, input logic [XLEN-1:0] imm,
                            input logic [XLEN-1:0] pc);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int t;
        t = 0;
        last_stall = 0;
        while ((pending[rob] || !disp_ready) && t < TIMEOUT) begin
            if (!disp_ready) begin
                last_stall++;
            end
            @(negedge clk);
            t++;
        end
        if (t >= TIMEOUT) begin
            timeouts++;
            $display("timeout: dispatch of rob %0d never found a free slot", rob);
            return;
        end
        a = (s1 == OP1_RS1) ? ref_regs[rs1] : (s1 == OP1_PC) ? pc : '0;
        b = (s2 == OP2_RS2) ? ref_regs[rs2] : (s2 == OP2_IMM) ? imm : '0;
        disp_uop = '{rob_id: rob, rd_phy: rd, rs1_phy: rs1, rs2_phy: rs2,
                     rs1_valid: !writer_pending(rs1), rs2_valid: !writer_pending(rs2),
                     op1_sel: s1, op2_sel: s2, fu_opcode: op, imm: imm, pc: pc};
        exp_val[rob] = alu_model(op, a, b);
        exp_rd[rob] = rd;
        use1[rob] = (s1 == OP1_RS1);
        use2[rob] = (s2 == OP2_RS2);
        src1[rob] = rs1;
        src2[rob] = rs2;
        pending[rob] = 1'b1;
        ref_regs[rd] = exp_val[rob];
        disp_valid = 1'b1;
        @(posedge clk);
        acc_t[rob] = $time;
        @(negedge clk);
        disp_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (any_pending() && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (t >= TIMEOUT) begin
            timeouts++;
            $display("timeout: results still outstanding");
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic imm_ops();
        for (int i = 0; i < 9; i++) begin
            dispatch(ROB_IDX'(i), fu_op_t'(4'(i)), (i % 2 == 1) ? OP1_PC : OP1_ZERO, OP2_IMM,
                     0, 0, PHY_IDX'(i + 1), $urandom, $urandom);
            wait_idle();
            // two cycles from acceptance when the unit is idle
            if (i != 8 && got_t[i] - acc_t[i] != 16) begin
                errors++;
                $display("[FAIL] %0t: rob %0d latency %0d cycles, expected 2", $time, i,
                         (got_t[i] - acc_t[i]) / 8);
            end
        end
    endtask

    task automatic dep_chain();
        dispatch(0, FU_ADD, OP1_ZERO, OP2_IMM, 0, 0, 10, $urandom, 0);
        dispatch(1, FU_ADD, OP1_RS1, OP2_IMM, 10, 0, 11, $urandom, 0);
        dispatch(2, FU_SUB, OP1_RS1, OP2_RS2, 11, 10, 12, 0, 0);
        dispatch(3, FU_SLL, OP1_RS1, OP2_IMM, 12, 0, 13, 3, 0);
        dispatch(4, FU_XOR, OP1_RS1, OP2_RS2, 13, 11, 14, 0, 0);
        dispatch(5, FU_SLT, OP1_RS1, OP2_RS2, 10, 14, 15, 0, 0);
        wait_idle();
    endtask

    task automatic mul_backpressure();
        dispatch(0, FU_ADD, OP1_ZERO, OP2_IMM, 0, 0, 20, $urandom, 0);
        wait_idle();
        dispatch(1, FU_MUL, OP1_RS1, OP2_IMM, 20, 0, 21, $urandom, 0);
        dispatch(2, FU_ADD, OP1_ZERO, OP2_IMM, 0, 0, 22, $urandom, 0);
        dispatch(3, FU_OR, OP1_PC, OP2_IMM, 0, 0, 23, $urandom, $urandom);
        dispatch(4, FU_XOR, OP1_ZERO, OP2_IMM, 0, 0, 24, $urandom, 0);
        wait_idle();
        if (got_t[1] - acc_t[1] != 8 * (2 + MUL_CYCLES)) begin
            errors++;
            $display("[FAIL] %0t: multiply latency %0d cycles", $time, (got_t[1] - acc_t[1]) / 8);
        end
        for (int r = 2; r < 5; r++) begin
            if (got_t[r] <= got_t[1]) begin
                errors++;
                $display("[FAIL] %0t: rob %0d broadcast during the multiply", $time, r);
            end
        end
    endtask

    task automatic full_station();
        // multiply chain keeps the unit busy while rob 2 waits on its end
        dispatch(0, FU_MUL, OP1_PC, OP2_IMM, 0, 0, 1, $urandom, $urandom);
        dispatch(1, FU_MUL, OP1_RS1, OP2_IMM, 1, 0, 2, $urandom, 0);
        dispatch(2, FU_ADD, OP1_RS1, OP2_IMM, 2, 0, 3, $urandom, 0);
        for (int i = 0; i < 8; i++) begin
            dispatch(ROB_IDX'(i + 3), FU_ADD, OP1_ZERO, OP2_IMM, 0, 0, PHY_IDX'(i + 4),
                     $urandom, 0);
            if ((i < 7 && last_stall != 0) || (i == 7 && last_stall == 0)) begin
                errors++;
                $display("[FAIL] %0t: dispatch %0d stalled %0d cycles", $time, i, last_stall);
            end
        end
        wait_idle();
    endtask

    task automatic random_mix();
        logic [PHY_IDX-1:0] rd;
        int tries;
        for (int n = 0; n < 200; n++) begin
            rd = PHY_IDX'($urandom_range(PHY_REGS - 1));
            tries = 0;
            while (reg_busy(rd) && tries < TIMEOUT) begin
                @(negedge clk);
                rd = PHY_IDX'($urandom_range(PHY_REGS - 1));
                tries++;
            end
            if (tries >= TIMEOUT) begin
                timeouts++;
                $display("timeout: no free destination register for op %0d", n);
                return;
            end
            dispatch(ROB_IDX'(n), fu_op_t'(4'($urandom_range(8))),
                     op1_sel_t'(2'($urandom_range(2))), op2_sel_t'(2'($urandom_range(2))),
                     PHY_IDX'($urandom_range(PHY_REGS - 1)),
                     PHY_IDX'($urandom_range(PHY_REGS - 1)), rd, $urandom, $urandom);
        end
        wait_idle();
    endtask

    initial begin
        void'($urandom(28659));
        rst = 1'b1;
        disp_valid = 1'b0;
        disp_uop = '0;
        errors = 0;
        timeouts = 0;
        for (int i = 0; i < PHY_REGS; i++) begin
            ref_regs[i] = '0;
        end
        for (int r = 0; r < ROBS; r++) begin
            pending[r] = 1'b0;
            use1[r] = 1'b0;
            use2[r] = 1'b0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fork
            monitor_cdb();
        join_none
        imm_ops();
        dep_chain();
        mul_backpressure();
        full_station();
        random_mix();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/int_issue_pkg.sv
hdl/int_rs.sv
hdl/prf.sv
hdl/fu_alu.sv
hdl/int_issue_top.sv
dv/int_issue_tb.sv
dv/int_issue_asserts.sv

//--- hdl/fu_alu.sv
module fu_alu
    import int_issue_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    input  logic   issue_valid,
    output logic   alu_ready,
    input  issue_t issue,

    output cdb_t   cdb
);
    // multiplier bits consumed per busy cycle
    localparam int STEP_W  = XLEN / MUL_CYCLES;
    localparam int SHAMT_W = $clog2(XLEN);
    localparam int CNT_W   = $clog2(MUL_CYCLES);

    typedef enum logic {
        IDLE,
        BUSY
    } mul_state_t;

    mul_state_t         state;
    logic [CNT_W-1:0]   step_cnt;
    logic               issue_fire;

    logic [XLEN-1:0]    op1;
    logic [XLEN-1:0]    op2;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    alu_result;

    // shift-and-add datapath
    logic [XLEN-1:0]    mul_a;
    logic [XLEN-1:0]    mul_b;
    logic [XLEN-1:0]    mul_acc;
    logic [XLEN-1:0]    mul_next;

    // broadcast register
    logic               cdb_valid;
    logic [ROB_IDX-1:0] cdb_rob_id;
    logic [PHY_IDX-1:0] cdb_rd_phy;
    logic [XLEN-1:0]    cdb_value;

    assign alu_ready  = (state == IDLE);
    assign issue_fire = issue_valid && alu_ready;

    //////////////////////////////
    // operands and ALU
    //////////////////////////////

    always_comb begin
        unique case (issue.op1_sel)
            OP1_RS1: op1 = issue.rs1_value;
            OP1_PC:  op1 = issue.pc;
            default: op1 = '0;
        endcase
        unique case (issue.op2_sel)
            OP2_RS2: op2 = issue.rs2_value;
            OP2_IMM: op2 = issue.imm;
            default: op2 = '0;
        endcase
    end

    assign shamt = op2[SHAMT_W-1:0];

    always_comb begin
        unique case (issue.fu_opcode)
            FU_ADD:  alu_result = op1 + op2;
            FU_SUB:  alu_result = op1 - op2;
            FU_AND:  alu_result = op1 & op2;
            FU_OR:   alu_result = op1 | op2;
            FU_XOR:  alu_result = op1 ^ op2;
            FU_SLL:  alu_result = op1 << shamt;
            FU_SRL:  alu_result = op1 >> shamt;
            FU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            // product comes from the multiplier path
            default: alu_result = '0;
        endcase
    end

    //////////////////////////////
    // multiplier
    //////////////////////////////

    // low XLEN bits only, upper partial terms drop out
    assign mul_next = mul_acc + mul_a * XLEN'(mul_b[STEP_W-1:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            step_cnt  <= '0;
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= 1'b0;
            unique case (state)
                IDLE: begin
                    if (issue_fire) begin
                        if (issue.fu_opcode == FU_MUL) begin
                            state    <= BUSY;
                            step_cnt <= CNT_W'(MUL_CYCLES - 1);
                        end else begin
                            cdb_valid <= 1'b1;
                        end
                    end
                end
                BUSY: begin
                    step_cnt <= step_cnt - 1'b1;
                    // last step also broadcasts
                    if (step_cnt == '0) begin
                        state     <= IDLE;
                        cdb_valid <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // tags stay put while busy, no other issue can land
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            if (issue_fire) begin
                cdb_rob_id <= issue.rob_id;
                cdb_rd_phy <= issue.rd_phy;
                cdb_value  <= alu_result;
                mul_a      <= op1;
                mul_b      <= op2;
                mul_acc    <= '0;
            end
        end else begin
            mul_a   <= mul_a << STEP_W;
            mul_b   <= mul_b >> STEP_W;
            mul_acc <= mul_next;
            if (step_cnt == '0) begin
                cdb_value <= mul_next;
            end
        end
    end

    always_comb begin
        cdb.valid  = cdb_valid;
        cdb.rob_id = cdb_rob_id;
        cdb.rd_phy = cdb_rd_phy;
        cdb.value  = cdb_value;
    end

endmodule

//--- hdl/int_issue_pkg.sv
package int_issue_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    localparam int XLEN       = 32;
    localparam int PHY_REGS   = 32;
    localparam int PHY_IDX    = 5;
    localparam int ROB_IDX    = 4;

    // busy cycles of the iterative multiplier
    localparam int MUL_CYCLES = 4;

    //////////////////////////////
    // encodings
    //////////////////////////////

    typedef enum logic [3:0] {
        FU_ADD = 4'd0,
        FU_SUB = 4'd1,
        FU_AND = 4'd2,
        FU_OR  = 4'd3,
        FU_XOR = 4'd4,
        FU_SLL = 4'd5,
        FU_SRL = 4'd6,
        FU_SLT = 4'd7,
        FU_MUL = 4'd8
    } fu_op_t;

    typedef enum logic [1:0] {
        OP1_ZERO = 2'd0,
        OP1_RS1  = 2'd1,
        OP1_PC   = 2'd2
    } op1_sel_t;

    typedef enum logic [1:0] {
        OP2_ZERO = 2'd0,
        OP2_RS2  = 2'd1,
        OP2_IMM  = 2'd2
    } op2_sel_t;

    //////////////////////////////
    // bundles
    //////////////////////////////

    // renamed micro-op as it leaves rename
    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [PHY_IDX-1:0] rd_phy;
        logic [PHY_IDX-1:0] rs1_phy;
        logic [PHY_IDX-1:0] rs2_phy;
        logic               rs1_valid;
        logic               rs2_valid;
        op1_sel_t           op1_sel;
        op2_sel_t           op2_sel;
        fu_op_t             fu_opcode;
        logic [XLEN-1:0]    imm;
        logic [XLEN-1:0]    pc;
    } uop_t;

    // station to functional unit, operands already read
    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [PHY_IDX-1:0] rd_phy;
        op1_sel_t           op1_sel;
        op2_sel_t           op2_sel;
        fu_op_t             fu_opcode;
        logic [XLEN-1:0]    imm;
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    rs1_value;
        logic [XLEN-1:0]    rs2_value;
    } issue_t;

    typedef struct packed {
        logic               valid;
        logic [ROB_IDX-1:0] rob_id;
        logic [PHY_IDX-1:0] rd_phy;
        logic [XLEN-1:0]    value;
    } cdb_t;

endpackage

//--- hdl/int_issue_top.sv
module int_issue_top
    import int_issue_pkg::*;
#(
    parameter int RS_DEPTH = 8
) (
    input  logic clk,
    input  logic rst,

    input  logic disp_valid,
    output logic disp_ready,
    input  uop_t disp_uop,

    output cdb_t cdb
);
    // station to register file
    logic [PHY_IDX-1:0] rs1_phy;
    logic [PHY_IDX-1:0] rs2_phy;
    logic [XLEN-1:0]    rs1_value;
    logic [XLEN-1:0]    rs2_value;

    // station to functional unit
    logic               issue_valid;
    logic               alu_ready;
    issue_t             issue;

    int_rs #(
        .RS_DEPTH    (RS_DEPTH)
    ) int_rs_i (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .disp_ready  (disp_ready),
        .disp_uop    (disp_uop),
        .rs1_phy     (rs1_phy),
        .rs2_phy     (rs2_phy),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .issue_valid (issue_valid),
        .alu_ready   (alu_ready),
        .issue       (issue),
        .cdb         (cdb)
    );

    prf prf_i (
        .clk         (clk),
        .rst         (rst),
        .rs1_phy     (rs1_phy),
        .rs2_phy     (rs2_phy),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .cdb         (cdb)
    );

    // sole CDB driver, also feeds wakeup and writeback
    fu_alu fu_alu_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .alu_ready   (alu_ready),
        .issue       (issue),
        .cdb         (cdb)
    );

endmodule

//--- hdl/int_rs.sv
module int_rs
    import int_issue_pkg::*;
#(
    parameter int RS_DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst,

    // dispatch
    input  logic               disp_valid,
    output logic               disp_ready,
    input  uop_t               disp_uop,

    // register file read
    output logic [PHY_IDX-1:0] rs1_phy,
    output logic [PHY_IDX-1:0] rs2_phy,
    input  logic [XLEN-1:0]    rs1_value,
    input  logic [XLEN-1:0]    rs2_value,

    // issue to the functional unit
    output logic               issue_valid,
    input  logic               alu_ready,
    output issue_t             issue,

    input  cdb_t               cdb
);
    localparam int RS_IDX = $clog2(RS_DEPTH);

    // entry storage and occupancy
    uop_t                entry [RS_DEPTH];
    logic [RS_DEPTH-1:0] busy;

    // per-entry readiness, counting the broadcast in flight
    logic [RS_DEPTH-1:0] src1_ok;
    logic [RS_DEPTH-1:0] src2_ok;
    logic [RS_DEPTH-1:0] entry_ready;

    logic                push_en;
    logic [RS_IDX-1:0]   push_idx;
    logic                issue_fire;
    logic [RS_IDX-1:0]   issue_idx;
    uop_t                sel;
    uop_t                disp_woken;

    function automatic logic cdb_hit(input cdb_t bus, input logic [PHY_IDX-1:0] phy);
        return bus.valid && (bus.rd_phy == phy);
    endfunction

    //////////////////////////////
    // allocation
    //////////////////////////////

    assign disp_ready = ~&busy;
    assign push_en    = disp_valid && disp_ready;

    // lowest free entry wins
    always_comb begin
        push_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                push_idx = RS_IDX'(i);
            end
        end
    end

    // a producer broadcasting on the dispatch edge would otherwise be missed
    always_comb begin
        disp_woken = disp_uop;
        if (cdb_hit(cdb, disp_uop.rs1_phy)) begin
            disp_woken.rs1_valid = 1'b1;
        end
        if (cdb_hit(cdb, disp_uop.rs2_phy)) begin
            disp_woken.rs2_valid = 1'b1;
        end
    end

    //////////////////////////////
    // wakeup and select
    //////////////////////////////

    // sources not read from a register are always ready
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            src1_ok[i] = (entry[i].op1_sel != OP1_RS1) || entry[i].rs1_valid
                         || cdb_hit(cdb, entry[i].rs1_phy);
            src2_ok[i] = (entry[i].op2_sel != OP2_RS2) || entry[i].rs2_valid
                         || cdb_hit(cdb, entry[i].rs2_phy);
        end
    end

    assign entry_ready = busy & src1_ok & src2_ok;
    assign issue_valid = |entry_ready;
    assign issue_fire  = issue_valid && alu_ready;

    // lowest ready entry wins
    always_comb begin
        issue_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (entry_ready[i]) begin
                issue_idx = RS_IDX'(i);
            end
        end
    end

    //////////////////////////////
    // entry update
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (push_en) begin
                busy[push_idx] <= 1'b1;
            end
            // never the entry being filled, that one was free
            if (issue_fire) begin
                busy[issue_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (busy[i] && cdb_hit(cdb, entry[i].rs1_phy)) begin
                entry[i].rs1_valid <= 1'b1;
            end
            if (busy[i] && cdb_hit(cdb, entry[i].rs2_phy)) begin
                entry[i].rs2_valid <= 1'b1;
            end
        end
        if (push_en) begin
            entry[push_idx] <= disp_woken;
        end
    end

    //////////////////////////////
    // operand read and issue
    //////////////////////////////

    assign sel     = entry[issue_idx];
    assign rs1_phy = sel.rs1_phy;
    assign rs2_phy = sel.rs2_phy;

    always_comb begin
        issue.rob_id    = sel.rob_id;
        issue.rd_phy    = sel.rd_phy;
        issue.op1_sel   = sel.op1_sel;
        issue.op2_sel   = sel.op2_sel;
        issue.fu_opcode = sel.fu_opcode;
        issue.imm       = sel.imm;
        issue.pc        = sel.pc;
        issue.rs1_value = rs1_value;
        issue.rs2_value = rs2_value;
    end

endmodule

//--- hdl/prf.sv
module prf
    import int_issue_pkg::*;
(
    input  logic               clk,
    input  logic               rst,

    input  logic [PHY_IDX-1:0] rs1_phy,
    input  logic [PHY_IDX-1:0] rs2_phy,
    output logic [XLEN-1:0]    rs1_value,
    output logic [XLEN-1:0]    rs2_value,

    input  cdb_t               cdb
);
    logic [XLEN-1:0] regs [PHY_REGS];

    //////////////////////////////
    // write from the CDB
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHY_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (cdb.valid) begin
            regs[cdb.rd_phy] <= cdb.value;
        end
    end

    //////////////////////////////
    // read with bypass
    //////////////////////////////

    // value being broadcast is not in the array until the edge
    assign rs1_value = (cdb.valid && (cdb.rd_phy == rs1_phy)) ? cdb.value : regs[rs1_phy];
    assign rs2_value = (cdb.valid && (cdb.rd_phy == rs2_phy)) ? cdb.value : regs[rs2_phy];

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module int_issue_tb -f files.f -o int_issue_sim
out=$(./obj_dir/int_issue_sim)
echo "$out"

if echo "$out" | grep -q "^=== PASS ===$"; then
    exit 0
else
    exit 1
fi
